/* include/dispatch_defs.svh */
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// Datapath widths
`define DATA_W 32
`define REG_ADDR_W 5
`define GR_COUNT 32

// Instruction field widths
`define CMD_W 5
`define CC_W 4

// Processor ID and revision, read back through CPUIDR
`define CPUIDR_VALUE 32'h3200_0101

// PCR reads one instruction behind the fetch pc
`define PC_STEP 32'h4

`endif

/* src/dispatch_pkg.sv */
`default_nettype none

`include "dispatch_defs.svh"

package dispatch_pkg;

	// System register indices kept in this core
	typedef enum logic [`REG_ADDR_W-1:0] {
		SYSREG_CPUIDR = 5'h00,
		SYSREG_TIDR   = 5'h02,
		SYSREG_PCR    = 5'h04,
		SYSREG_SPR    = 5'h05,
		SYSREG_PSR    = 5'h06,
		SYSREG_PPSR   = 5'h0b,
		SYSREG_PTIDR  = 5'h0f
	} sysreg_idx_e;

	typedef struct packed {
		logic sys_reg;
		logic sys_ldst;
		logic logic_op;
		logic shift;
		logic adder;
		logic mul;
		logic sdiv;
		logic udiv;
		logic ldst;
		logic branch;
	} ex_unit_t;

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] destination;
		logic destination_sysreg;
		logic writeback;
		logic flags_writeback;
		logic [`CMD_W-1:0] cmd;
		logic [`CC_W-1:0] cc_afe;
		logic [`REG_ADDR_W-1:0] source0;
		logic [`REG_ADDR_W-1:0] source1;
		logic source0_sysreg;
		logic source1_sysreg;
		logic source1_imm;
		logic source0_flags;
		ex_unit_t ex;
		logic [`DATA_W-1:0] pc;
	} dispatch_payload_t;

endpackage

`default_nettype wire

/* src/wb_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_defs.svh"

interface wb_if;
	logic valid;
	logic [`DATA_W-1:0] data;
	logic [`REG_ADDR_W-1:0] destination;
	logic destination_sysreg;
	logic writeback;
	logic spr_writeback;
	logic [`DATA_W-1:0] spr;
	logic [`DATA_W-1:0] pc;
	logic branch;
	logic [`DATA_W-1:0] branch_pc;

	modport driver (output valid, data, destination, destination_sysreg, writeback,
		spr_writeback, spr, pc, branch, branch_pc);
	modport gr_sink (input valid, data, destination, destination_sysreg, writeback);
	modport sys_sink (input valid, data, destination, destination_sysreg, writeback,
		spr_writeback, spr, pc, branch, branch_pc);
	// Forwarding never needs the branch target
	modport fwd_sink (input valid, data, destination, destination_sysreg, writeback,
		spr_writeback, spr, pc);
endinterface

`default_nettype wire

/* src/gr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_defs.svh"

module gr_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic pipeline_stop,
	wb_if.gr_sink wb,
	input logic [`REG_ADDR_W-1:0] rd0_addr,
	input logic [`REG_ADDR_W-1:0] rd1_addr,
	output logic [`DATA_W-1:0] rd0_data,
	output logic [`DATA_W-1:0] rd1_data
);

	logic [`DATA_W-1:0] regs [`GR_COUNT];
	logic wr_en;

	assign wr_en = wb.valid && !wb.destination_sysreg && wb.writeback && !pipeline_stop;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `GR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.destination] <= wb.data;
		end
	end

	// Forwarding sits outside, so reads see the old value here
	assign rd0_data = regs[rd0_addr];
	assign rd1_data = regs[rd1_addr];

	// A write to an unknown address would corrupt the whole file
	a_wr_dest_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		wr_en |-> !$isunknown(wb.destination)
	) else $error("gr_file write with unknown destination");

endmodule

`default_nettype wire

/* src/sysreg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_defs.svh"

module sysreg_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic pipeline_stop,
	input logic register_lock,
	input logic set_irq_mode,
	input logic clr_irq_mode,
	wb_if.sys_sink wb,
	input logic [`REG_ADDR_W-1:0] rd0_idx,
	input logic [`REG_ADDR_W-1:0] rd1_idx,
	input logic [`DATA_W-1:0] rd_pc,
	output logic rd0_hit,
	output logic [`DATA_W-1:0] rd0_data,
	output logic rd1_hit,
	output logic [`DATA_W-1:0] rd1_data,
	output logic [`DATA_W-1:0] pcr,
	output logic [`DATA_W-1:0] spr,
	output logic [`DATA_W-1:0] psr,
	output logic [`DATA_W-1:0] ppsr,
	output logic [`DATA_W-1:0] tidr
);
	import dispatch_pkg::*;

	// Interrupt enable bits 6:5 and bit 2 drop on IRQ entry
	localparam logic [`DATA_W-1:0] IRQ_CLR_MASK = 32'h0000_0064;

	logic [`DATA_W-1:0] ptidr;
	logic sys_wr;
	logic spr_wr;
	logic pcr_wr;

	assign sys_wr = !pipeline_stop && wb.valid && wb.destination_sysreg && wb.writeback;
	assign spr_wr = !pipeline_stop && wb.valid && wb.spr_writeback;
	assign pcr_wr = !pipeline_stop && wb.valid && !register_lock;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr <= '0;
			spr <= '0;
			psr <= '0;
			ppsr <= '0;
			tidr <= '0;
			ptidr <= '0;
		end else begin
			if (pcr_wr) begin
				pcr <= wb.branch ? wb.branch_pc : wb.pc;
			end
			if (spr_wr) begin
				spr <= wb.spr;
			end else if (sys_wr && wb.destination == SYSREG_SPR) begin
				spr <= wb.data;
			end
			// IRQ entry and exit take precedence over writeback
			if (set_irq_mode) begin
				psr <= psr & ~IRQ_CLR_MASK;
				ppsr <= psr;
				ptidr <= tidr;
			end else begin
				if (clr_irq_mode) begin
					psr <= ppsr;
				end else if (sys_wr && wb.destination == SYSREG_PSR) begin
					psr <= wb.data;
				end
				if (sys_wr && wb.destination == SYSREG_PPSR) begin
					ppsr <= wb.data;
				end
				if (sys_wr && wb.destination == SYSREG_PTIDR) begin
					ptidr <= wb.data;
				end
			end
			if (sys_wr && wb.destination == SYSREG_TIDR) begin
				tidr <= wb.data;
			end
		end
	end

	function automatic logic [`DATA_W:0] read_port(input logic [`REG_ADDR_W-1:0] idx);
		case (idx)
			SYSREG_CPUIDR: return {1'b1, `CPUIDR_VALUE};
			SYSREG_TIDR: return {1'b1, tidr};
			SYSREG_PCR: return {1'b1, rd_pc - `PC_STEP};
			SYSREG_SPR: return {1'b1, spr};
			SYSREG_PSR: return {1'b1, psr};
			SYSREG_PPSR: return {1'b1, ppsr};
			SYSREG_PTIDR: return {1'b1, ptidr};
			default: return '0;
		endcase
	endfunction

	always_comb begin
		{rd0_hit, rd0_data} = read_port(rd0_idx);
		{rd1_hit, rd1_data} = read_port(rd1_idx);
	end

	a_irq_exclusive: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(set_irq_mode && clr_irq_mode)
	) else $error("IRQ mode set and clear strobed together");

endmodule

`default_nettype wire

/* src/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_defs.svh"

module operand_select (
	wb_if.fwd_sink wb,
	input dispatch_pkg::dispatch_payload_t payload,
	input logic [`DATA_W-1:0] imm1,
	input logic [`DATA_W-1:0] gr0,
	input logic [`DATA_W-1:0] gr1,
	input logic sys0_hit,
	input logic [`DATA_W-1:0] sys0,
	input logic sys1_hit,
	input logic [`DATA_W-1:0] sys1,
	output logic [`DATA_W-1:0] operand0,
	output logic [`DATA_W-1:0] operand1
);
	import dispatch_pkg::*;

	// Returns {match, value} for a same-cycle writeback
	function automatic logic [`DATA_W:0] forward(
		input logic [`REG_ADDR_W-1:0] ptr,
		input logic sysreg
	);
		if (!wb.valid) begin
			return '0;
		end
		if (sysreg) begin
			if (!wb.destination_sysreg) begin
				return '0;
			end
			if (ptr == SYSREG_PCR) begin
				return {1'b1, wb.pc};
			end
			if (ptr == SYSREG_SPR && wb.spr_writeback) begin
				return {1'b1, wb.spr};
			end
			if (ptr == wb.destination && wb.writeback) begin
				return {1'b1, wb.data};
			end
			return '0;
		end
		if (!wb.destination_sysreg && ptr == wb.destination && wb.writeback) begin
			return {1'b1, wb.data};
		end
		return '0;
	endfunction

	logic fwd0_hit;
	logic fwd1_hit;
	logic [`DATA_W-1:0] fwd0;
	logic [`DATA_W-1:0] fwd1;

	always_comb begin
		{fwd0_hit, fwd0} = forward(payload.source0, payload.source0_sysreg);
		{fwd1_hit, fwd1} = forward(payload.source1, payload.source1_sysreg);
	end

	always_comb begin
		if (fwd0_hit) begin
			operand0 = fwd0;
		end else if (payload.source0_sysreg && sys0_hit) begin
			operand0 = sys0;
		end else begin
			operand0 = gr0;
		end
	end

	// Immediate wins over everything on source 1
	always_comb begin
		if (payload.source1_imm) begin
			operand1 = imm1;
		end else if (fwd1_hit) begin
			operand1 = fwd1;
		end else if (payload.source1_sysreg && sys1_hit) begin
			operand1 = sys1;
		end else begin
			operand1 = gr1;
		end
	end

endmodule

`default_nettype wire

/* src/dispatch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_defs.svh"

module dispatch_stage (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic next_lock,
	input logic previous_valid,
	input dispatch_pkg::dispatch_payload_t payload_in,
	input logic [`DATA_W-1:0] operand0_in,
	input logic [`DATA_W-1:0] operand1_in,
	output logic next_valid,
	output dispatch_pkg::dispatch_payload_t payload_out,
	output logic [`DATA_W-1:0] operand0_out,
	output logic [`DATA_W-1:0] operand1_out
);

	logic valid_r;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_r <= 1'b0;
			payload_out <= '0;
			operand0_out <= '0;
			operand1_out <= '0;
		end else if (refresh) begin
			valid_r <= 1'b0;
			payload_out <= '0;
			operand0_out <= '0;
			operand1_out <= '0;
		end else if (!next_lock) begin
			valid_r <= previous_valid;
			payload_out <= payload_in;
			operand0_out <= operand0_in;
			operand1_out <= operand1_in;
		end
	end

	// Held entry is hidden while downstream is stalled
	assign next_valid = valid_r && !next_lock;

	// An unknown valid would leak into the next stage
	a_valid_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!next_lock && !refresh |-> !$isunknown(previous_valid)
	) else $error("previous_valid unknown when captured");

endmodule

`default_nettype wire

/* src/dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_defs.svh"

module dispatch_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic register_lock,
	input logic pipeline_stop,
	input logic refresh,
	input logic set_irq_mode,
	input logic clr_irq_mode,
	// Previous stage
	input logic previous_valid,
	input logic [`REG_ADDR_W-1:0] previous_destination,
	input logic previous_destination_sysreg,
	input logic previous_writeback,
	input logic previous_flags_writeback,
	input logic [`CMD_W-1:0] previous_cmd,
	input logic [`CC_W-1:0] previous_cc_afe,
	input logic [`REG_ADDR_W-1:0] previous_source0,
	input logic [`DATA_W-1:0] previous_source1,
	input logic previous_source0_sysreg,
	input logic previous_source1_sysreg,
	input logic previous_source1_imm,
	input logic previous_source0_flags,
	input logic previous_ex_sys_reg,
	input logic previous_ex_sys_ldst,
	input logic previous_ex_logic,
	input logic previous_ex_shift,
	input logic previous_ex_adder,
	input logic previous_ex_mul,
	input logic previous_ex_sdiv,
	input logic previous_ex_udiv,
	input logic previous_ex_ldst,
	input logic previous_ex_branch,
	input logic [`DATA_W-1:0] previous_pc,
	output logic prev_lock,
	// Next stage
	output logic next_valid,
	output logic [`REG_ADDR_W-1:0] next_destination,
	output logic next_destination_sysreg,
	output logic next_writeback,
	output logic next_flags_writeback,
	output logic [`CMD_W-1:0] next_cmd,
	output logic [`CC_W-1:0] next_cc_afe,
	output logic [`DATA_W-1:0] next_source0,
	output logic [`DATA_W-1:0] next_source1,
	output logic [`REG_ADDR_W-1:0] next_source0_pointer,
	output logic [`REG_ADDR_W-1:0] next_source1_pointer,
	output logic next_source0_sysreg,
	output logic next_source1_sysreg,
	output logic next_source1_imm,
	output logic next_source0_flags,
	output logic next_ex_sys_reg,
	output logic next_ex_sys_ldst,
	output logic next_ex_logic,
	output logic next_ex_shift,
	output logic next_ex_adder,
	output logic next_ex_mul,
	output logic next_ex_sdiv,
	output logic next_ex_udiv,
	output logic next_ex_ldst,
	output logic next_ex_branch,
	output logic [`DATA_W-1:0] next_pc,
	input logic next_lock,
	// Writeback
	input logic wb_valid,
	input logic [`DATA_W-1:0] wb_data,
	input logic [`REG_ADDR_W-1:0] wb_destination,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input logic [`DATA_W-1:0] wb_spr,
	input logic [`DATA_W-1:0] wb_pc,
	input logic wb_branch,
	input logic [`DATA_W-1:0] wb_branch_pc,
	// System register view
	output logic [`DATA_W-1:0] sysreg_pcr,
	output logic [`DATA_W-1:0] sysreg_spr,
	output logic [`DATA_W-1:0] sysreg_psr,
	output logic [`DATA_W-1:0] sysreg_ppsr,
	output logic [`DATA_W-1:0] sysreg_tidr
);
	import dispatch_pkg::*;

	dispatch_payload_t prev_payload;
	dispatch_payload_t stage_payload;
	logic [`DATA_W-1:0] gr0;
	logic [`DATA_W-1:0] gr1;
	logic sys0_hit;
	logic sys1_hit;
	logic [`DATA_W-1:0] sys0;
	logic [`DATA_W-1:0] sys1;
	logic [`DATA_W-1:0] operand0;
	logic [`DATA_W-1:0] operand1;

	wb_if wb ();

	assign wb.valid = wb_valid;
	assign wb.data = wb_data;
	assign wb.destination = wb_destination;
	assign wb.destination_sysreg = wb_destination_sysreg;
	assign wb.writeback = wb_writeback;
	assign wb.spr_writeback = wb_spr_writeback;
	assign wb.spr = wb_spr;
	assign wb.pc = wb_pc;
	assign wb.branch = wb_branch;
	assign wb.branch_pc = wb_branch_pc;

	always_comb begin
		prev_payload.destination = previous_destination;
		prev_payload.destination_sysreg = previous_destination_sysreg;
		prev_payload.writeback = previous_writeback;
		prev_payload.flags_writeback = previous_flags_writeback;
		prev_payload.cmd = previous_cmd;
		prev_payload.cc_afe = previous_cc_afe;
		prev_payload.source0 = previous_source0;
		// Pointer is the low bits of the shared source 1 field
		prev_payload.source1 = previous_source1[`REG_ADDR_W-1:0];
		prev_payload.source0_sysreg = previous_source0_sysreg;
		prev_payload.source1_sysreg = previous_source1_sysreg;
		prev_payload.source1_imm = previous_source1_imm;
		prev_payload.source0_flags = previous_source0_flags;
		prev_payload.ex = {previous_ex_sys_reg, previous_ex_sys_ldst, previous_ex_logic,
			previous_ex_shift, previous_ex_adder, previous_ex_mul, previous_ex_sdiv,
			previous_ex_udiv, previous_ex_ldst, previous_ex_branch};
		prev_payload.pc = previous_pc;
	end

	gr_file i_gr (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.pipeline_stop(pipeline_stop),
		.wb(wb.gr_sink),
		.rd0_addr(prev_payload.source0),
		.rd1_addr(prev_payload.source1),
		.rd0_data(gr0),
		.rd1_data(gr1)
	);

	sysreg_file i_sys (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.pipeline_stop(pipeline_stop),
		.register_lock(register_lock),
		.set_irq_mode(set_irq_mode),
		.clr_irq_mode(clr_irq_mode),
		.wb(wb.sys_sink),
		.rd0_idx(prev_payload.source0),
		.rd1_idx(prev_payload.source1),
		.rd_pc(previous_pc),
		.rd0_hit(sys0_hit),
		.rd0_data(sys0),
		.rd1_hit(sys1_hit),
		.rd1_data(sys1),
		.pcr(sysreg_pcr),
		.spr(sysreg_spr),
		.psr(sysreg_psr),
		.ppsr(sysreg_ppsr),
		.tidr(sysreg_tidr)
	);

	operand_select i_sel (
		.wb(wb.fwd_sink),
		.payload(prev_payload),
		.imm1(previous_source1),
		.gr0(gr0),
		.gr1(gr1),
		.sys0_hit(sys0_hit),
		.sys0(sys0),
		.sys1_hit(sys1_hit),
		.sys1(sys1),
		.operand0(operand0),
		.operand1(operand1)
	);

	dispatch_stage i_stage (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.refresh(refresh),
		.next_lock(next_lock),
		.previous_valid(previous_valid),
		.payload_in(prev_payload),
		.operand0_in(operand0),
		.operand1_in(operand1),
		.next_valid(next_valid),
		.payload_out(stage_payload),
		.operand0_out(next_source0),
		.operand1_out(next_source1)
	);

	assign prev_lock = next_lock;

	assign next_destination = stage_payload.destination;
	assign next_destination_sysreg = stage_payload.destination_sysreg;
	assign next_writeback = stage_payload.writeback;
	assign next_flags_writeback = stage_payload.flags_writeback;
	assign next_cmd = stage_payload.cmd;
	assign next_cc_afe = stage_payload.cc_afe;
	assign next_source0_pointer = stage_payload.source0;
	assign next_source1_pointer = stage_payload.source1;
	assign next_source0_sysreg = stage_payload.source0_sysreg;
	assign next_source1_sysreg = stage_payload.source1_sysreg;
	assign next_source1_imm = stage_payload.source1_imm;
	assign next_source0_flags = stage_payload.source0_flags;
	assign {next_ex_sys_reg, next_ex_sys_ldst, next_ex_logic, next_ex_shift, next_ex_adder,
		next_ex_mul, next_ex_sdiv, next_ex_udiv, next_ex_ldst, next_ex_branch} = stage_payload.ex;
	assign next_pc = stage_payload.pc;

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic iCLOCK,
	output logic inRESET
);

	initial begin
		iCLOCK = 1'b0;
		forever #(PERIOD_NS / 2) iCLOCK = ~iCLOCK;
	end

	// Reset leaves on a rising edge
	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		inRESET <= 1'b1;
	end

endmodule

`default_nettype wire

/* tb/tb_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_defs.svh"

module tb_dispatch;
	import dispatch_pkg::*;

	localparam int PERIOD_NS = 4;
	localparam int RESET_CYCLES = 2;
	localparam int N_CYCLES = 600;
	localparam int DRAIN_CYCLES = 4;
	localparam int MARGIN_CYCLES = 50;
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + N_CYCLES + DRAIN_CYCLES + MARGIN_CYCLES) * PERIOD_NS;
	localparam logic [`DATA_W-1:0] IRQ_MASK = 32'h0000_0064;

	// Kept indices plus one dropped index that has to miss
	localparam logic [`REG_ADDR_W-1:0] SYS_IDX [8] = '{SYSREG_CPUIDR, SYSREG_TIDR,
		SYSREG_PCR, SYSREG_SPR, SYSREG_PSR, SYSREG_PPSR, SYSREG_PTIDR, 5'h09};

	logic iCLOCK;
	logic inRESET;
	logic register_lock, pipeline_stop, refresh, set_irq_mode, clr_irq_mode;
	logic previous_valid, previous_destination_sysreg, previous_writeback;
	logic previous_flags_writeback, previous_source0_sysreg, previous_source1_sysreg;
	logic previous_source1_imm, previous_source0_flags;
	logic previous_ex_sys_reg, previous_ex_sys_ldst, previous_ex_logic, previous_ex_shift;
	logic previous_ex_adder, previous_ex_mul, previous_ex_sdiv, previous_ex_udiv;
	logic previous_ex_ldst, previous_ex_branch;
	logic [`REG_ADDR_W-1:0] previous_destination, previous_source0;
	logic [`CMD_W-1:0] previous_cmd;
	logic [`CC_W-1:0] previous_cc_afe;
	logic [`DATA_W-1:0] previous_source1, previous_pc;
	logic next_lock, prev_lock;
	logic wb_valid, wb_destination_sysreg, wb_writeback, wb_spr_writeback, wb_branch;
	logic [`REG_ADDR_W-1:0] wb_destination;
	logic [`DATA_W-1:0] wb_data, wb_spr, wb_pc, wb_branch_pc;
	logic next_valid, next_destination_sysreg, next_writeback, next_flags_writeback;
	logic next_source0_sysreg, next_source1_sysreg, next_source1_imm, next_source0_flags;
	logic next_ex_sys_reg, next_ex_sys_ldst, next_ex_logic, next_ex_shift, next_ex_adder;
	logic next_ex_mul, next_ex_sdiv, next_ex_udiv, next_ex_ldst, next_ex_branch;
	logic [`REG_ADDR_W-1:0] next_destination, next_source0_pointer, next_source1_pointer;
	logic [`CMD_W-1:0] next_cmd;
	logic [`CC_W-1:0] next_cc_afe;
	logic [`DATA_W-1:0] next_source0, next_source1, next_pc;
	logic [`DATA_W-1:0] sysreg_pcr, sysreg_spr, sysreg_psr, sysreg_ppsr, sysreg_tidr;

	// Remaining payload fields as one vector
	logic [35:0] next_fields;

	// Shadow registers and expected stage contents
	logic [`DATA_W-1:0] m_gr [`GR_COUNT];
	logic [`DATA_W-1:0] m_pcr, m_spr, m_psr, m_ppsr, m_tidr, m_ptidr;
	logic e_valid;
	logic [`DATA_W-1:0] e_src0, e_src1, e_pc;
	logic [`CMD_W-1:0] e_cmd;
	logic [35:0] e_fields;
	int mismatches = 0;
	int failures = 0;
	logic [31:0] seed = 32'hbc62_07af;

	tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_clk (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET)
	);

	dispatch_top i_dut (.*);

	assign next_fields = {next_destination, next_destination_sysreg, next_writeback,
		next_flags_writeback, next_cc_afe, next_source0_pointer, next_source1_pointer,
		next_source0_sysreg, next_source1_sysreg, next_source1_imm, next_source0_flags,
		next_ex_sys_reg, next_ex_sys_ldst, next_ex_logic, next_ex_shift, next_ex_adder,
		next_ex_mul, next_ex_sdiv, next_ex_udiv, next_ex_ldst, next_ex_branch};

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Returns the hit flag, value through the output argument
	function automatic logic sys_lookup(input logic [`REG_ADDR_W-1:0] idx,
		output logic [`DATA_W-1:0] value);
		value = '0;
		if (idx == SYSREG_CPUIDR) value = `CPUIDR_VALUE;
		else if (idx == SYSREG_TIDR) value = m_tidr;
		else if (idx == SYSREG_PCR) value = previous_pc - `PC_STEP;
		else if (idx == SYSREG_SPR) value = m_spr;
		else if (idx == SYSREG_PSR) value = m_psr;
		else if (idx == SYSREG_PPSR) value = m_ppsr;
		else if (idx == SYSREG_PTIDR) value = m_ptidr;
		else return 1'b0;
		return 1'b1;
	endfunction

	function automatic logic [`DATA_W-1:0] expect_operand(
		input logic [`REG_ADDR_W-1:0] ptr, input logic sysreg);
		logic [`DATA_W-1:0] sys_value;
		logic hit;
		hit = sys_lookup(ptr, sys_value);
		if (wb_valid && sysreg && wb_destination_sysreg) begin
			if (ptr == SYSREG_PCR) return wb_pc;
			if (ptr == SYSREG_SPR && wb_spr_writeback) return wb_spr;
			if (ptr == wb_destination && wb_writeback) return wb_data;
		end
		if (wb_valid && !sysreg && !wb_destination_sysreg && wb_writeback
			&& ptr == wb_destination) begin
			return wb_data;
		end
		if (sysreg && hit) return sys_value;
		return m_gr[ptr];
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		mismatches++;
		$display("MISMATCH %s: got %h, expected %h at %0t", name, got, expected, $time);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("FAILURE: %s at %0t", what, $time);
	endtask

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `GR_COUNT; i++) begin
				m_gr[i] <= '0;
			end
			{m_pcr, m_spr, m_psr, m_ppsr, m_tidr, m_ptidr} <= '0;
			{e_valid, e_src0, e_src1, e_pc, e_cmd, e_fields} <= '0;
		end else begin
			if (!pipeline_stop && wb_valid) begin
				if (wb_writeback && !wb_destination_sysreg) m_gr[wb_destination] <= wb_data;
				if (!register_lock) m_pcr <= wb_branch ? wb_branch_pc : wb_pc;
				if (wb_writeback && wb_destination_sysreg) begin
					case (wb_destination)
						SYSREG_TIDR: m_tidr <= wb_data;
						SYSREG_SPR: m_spr <= wb_data;
						SYSREG_PSR: m_psr <= wb_data;
						SYSREG_PPSR: m_ppsr <= wb_data;
						SYSREG_PTIDR: m_ptidr <= wb_data;
						default: ;
					endcase
				end
				if (wb_spr_writeback) m_spr <= wb_spr;
			end
			if (set_irq_mode) begin
				m_ppsr <= m_psr;
				m_ptidr <= m_tidr;
				m_psr <= m_psr & ~IRQ_MASK;
			end
			if (clr_irq_mode) m_psr <= m_ppsr;
			if (refresh) begin
				{e_valid, e_src0, e_src1, e_pc, e_cmd, e_fields} <= '0;
			end else if (!next_lock) begin
				e_valid <= previous_valid;
				e_src0 <= expect_operand(previous_source0, previous_source0_sysreg);
				e_src1 <= previous_source1_imm ? previous_source1
					: expect_operand(previous_source1[`REG_ADDR_W-1:0], previous_source1_sysreg);
				e_pc <= previous_pc;
				e_cmd <= previous_cmd;
				e_fields <= {previous_destination, previous_destination_sysreg,
					previous_writeback, previous_flags_writeback, previous_cc_afe,
					previous_source0, previous_source1[`REG_ADDR_W-1:0],
					previous_source0_sysreg, previous_source1_sysreg, previous_source1_imm,
					previous_source0_flags, previous_ex_sys_reg, previous_ex_sys_ldst,
					previous_ex_logic, previous_ex_shift, previous_ex_adder, previous_ex_mul,
					previous_ex_sdiv, previous_ex_udiv, previous_ex_ldst, previous_ex_branch};
			end
		end
	end

	a_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_valid == (e_valid && !next_lock))
		else report_mismatch("next_valid", $sampled(next_valid), $sampled(e_valid && !next_lock));
	a_src0: assert property (@(posedge iCLOCK) disable iff (!inRESET) next_source0 == e_src0)
		else report_mismatch("next_source0", $sampled(next_source0), $sampled(e_src0));
	a_src1: assert property (@(posedge iCLOCK) disable iff (!inRESET) next_source1 == e_src1)
		else report_mismatch("next_source1", $sampled(next_source1), $sampled(e_src1));
	a_pc: assert property (@(posedge iCLOCK) disable iff (!inRESET) next_pc == e_pc)
		else report_mismatch("next_pc", $sampled(next_pc), $sampled(e_pc));
	a_cmd: assert property (@(posedge iCLOCK) disable iff (!inRESET) next_cmd == e_cmd)
		else report_mismatch("next_cmd", $sampled(next_cmd), $sampled(e_cmd));
	a_fields: assert property (@(posedge iCLOCK) disable iff (!inRESET) next_fields == e_fields)
		else report_mismatch("next_fields", $sampled(next_fields), $sampled(e_fields));
	a_prev_lock: assert property (@(posedge iCLOCK) prev_lock == next_lock)
		else report_mismatch("prev_lock", $sampled(prev_lock), $sampled(next_lock));
	a_pcr: assert property (@(posedge iCLOCK) disable iff (!inRESET) sysreg_pcr == m_pcr)
		else report_mismatch("sysreg_pcr", $sampled(sysreg_pcr), $sampled(m_pcr));
	a_spr: assert property (@(posedge iCLOCK) disable iff (!inRESET) sysreg_spr == m_spr)
		else report_mismatch("sysreg_spr", $sampled(sysreg_spr), $sampled(m_spr));
	a_psr: assert property (@(posedge iCLOCK) disable iff (!inRESET) sysreg_psr == m_psr)
		else report_mismatch("sysreg_psr", $sampled(sysreg_psr), $sampled(m_psr));
	a_ppsr: assert property (@(posedge iCLOCK) disable iff (!inRESET) sysreg_ppsr == m_ppsr)
		else report_mismatch("sysreg_ppsr", $sampled(sysreg_ppsr), $sampled(m_ppsr));
	a_tidr: assert property (@(posedge iCLOCK) disable iff (!inRESET) sysreg_tidr == m_tidr)
		else report_mismatch("sysreg_tidr", $sampled(sysreg_tidr), $sampled(m_tidr));
	a_lock_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_lock && !refresh |=> $stable({next_pc, next_cmd, next_source0, next_source1}))
		else report_failure("next stage contents changed while next_lock was high");
	a_stop_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		pipeline_stop && !set_irq_mode && !clr_irq_mode
		|=> $stable({sysreg_pcr, sysreg_spr, sysreg_psr, sysreg_ppsr, sysreg_tidr}))
		else report_failure("a system register changed while pipeline_stop was high");

	initial begin
		logic [31:0] c, p, d, w;
		logic irq_set, irq_clr;
		{register_lock, pipeline_stop, refresh, set_irq_mode, clr_irq_mode, next_lock} = '0;
		{previous_valid, previous_destination, previous_destination_sysreg} = '0;
		{previous_writeback, previous_flags_writeback, previous_cmd, previous_cc_afe} = '0;
		{previous_source0, previous_source1, previous_source0_sysreg} = '0;
		{previous_source1_sysreg, previous_source1_imm, previous_source0_flags} = '0;
		{previous_ex_sys_reg, previous_ex_sys_ldst, previous_ex_logic, previous_ex_shift,
			previous_ex_adder, previous_ex_mul, previous_ex_sdiv, previous_ex_udiv,
			previous_ex_ldst, previous_ex_branch, previous_pc} = '0;
		{wb_valid, wb_data, wb_destination, wb_destination_sysreg, wb_writeback} = '0;
		{wb_spr_writeback, wb_spr, wb_pc, wb_branch, wb_branch_pc} = '0;
		@(posedge inRESET);
		// Small pointer ranges keep forwarding and read-after-write hits frequent
		repeat (N_CYCLES) begin
			@(posedge iCLOCK);
			seed = xorshift(seed);
			c = seed;
			seed = xorshift(seed);
			p = seed;
			seed = xorshift(seed);
			d = seed;
			seed = xorshift(seed);
			w = seed;
			irq_set = c[3:0] == 4'h0;
			irq_clr = c[3:0] == 4'h1;
			previous_valid <= c[4];
			previous_source0_sysreg <= c[5];
			previous_source0 <= c[5] ? SYS_IDX[p[2:0]] : {3'b000, p[1:0]};
			previous_source1_sysreg <= c[6];
			previous_source1_imm <= c[8:7] == 2'b11;
			previous_source1 <= (c[8:7] == 2'b11) ? d
				: {27'd0, c[6] ? SYS_IDX[p[5:3]] : {3'b000, p[4:3]}};
			previous_destination_sysreg <= c[9];
			previous_writeback <= c[10];
			previous_flags_writeback <= c[11];
			previous_source0_flags <= c[12];
			previous_cmd <= p[12:8];
			previous_destination <= p[17:13];
			previous_cc_afe <= d[3:0];
			{previous_ex_sys_reg, previous_ex_sys_ldst, previous_ex_logic, previous_ex_shift,
				previous_ex_adder, previous_ex_mul, previous_ex_sdiv, previous_ex_udiv,
				previous_ex_ldst, previous_ex_branch} <= p[27:18];
			previous_pc <= d & 32'hffff_fffc;
			wb_valid <= c[13] && !irq_set && !irq_clr;
			wb_destination_sysreg <= c[14];
			wb_destination <= c[14] ? SYS_IDX[p[30:28]] : {3'b000, p[29:28]};
			wb_writeback <= c[15];
			wb_spr_writeback <= c[17:16] == 2'b00;
			wb_branch <= c[18];
			wb_data <= w;
			wb_spr <= {d[15:0], d[31:16]};
			wb_pc <= w & 32'h00ff_fffc;
			wb_branch_pc <= ~w & 32'hffff_fffc;
			pipeline_stop <= c[21:19] == 3'd0;
			register_lock <= c[24:22] == 3'd0;
			next_lock <= c[27:25] < 3'd2;
			refresh <= c[31:28] == 4'h0;
			set_irq_mode <= irq_set;
			clr_irq_mode <= irq_clr;
		end
		@(posedge iCLOCK);
		{previous_valid, wb_valid, next_lock, refresh, set_irq_mode, clr_irq_mode} <= '0;
		repeat (DRAIN_CYCLES) @(posedge iCLOCK);
		$display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog expired before the stimulus finished");
		$display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
src/dispatch_pkg.sv
src/wb_if.sv
src/gr_file.sv
src/sysreg_file.sv
src/operand_select.sv
src/dispatch_stage.sv
src/dispatch_top.sv
tb/tb_clock_gen.sv
tb/tb_dispatch.sv

/* Bender.yml */
package:
  name: dispatch_stage

export_include_dirs:
  - include

sources:
  - files:
      - src/dispatch_pkg.sv
      - src/wb_if.sv
      - src/gr_file.sv
      - src/sysreg_file.sv
      - src/operand_select.sv
      - src/dispatch_stage.sv
      - src/dispatch_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_dispatch.sv
